/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath width, also the byte address width
`define XLEN 32

// instruction word width
`define INST_LEN 32

// gpr index width
// 32 architectural registers
`define REG_ADDRWIDTH 5

// addi x0, x0, 0
// reset value and bubble filler for the inst field
`define INST_NOP 32'h00000013

// local data memory size in 32-bit words
// 1 KiB total, address bits above this wrap
`define DMEM_WORDS 256

`endif

/* rv_types_pkg.sv */
`default_nettype none

`include "rv_consts.svh"

package rv_types_pkg;

  // data word, also used for byte addresses
  typedef logic [`XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [`INST_LEN-1:0] inst_t;

  // gpr index
  // zero means the slot writes nothing
  typedef logic [`REG_ADDRWIDTH-1:0] reg_addr_t;

  // word index into the data memory
  typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

  // one enable per byte lane of a data word
  typedef logic [`XLEN/8-1:0] byte_en_t;

endpackage

`default_nettype wire

/* rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

  // memory operation carried from execute
  // loads and stores follow the rv32i funct3 sizes
  typedef enum logic [3:0] {
    // no access, alu result passes through
    MEM_NONE = 4'd0,
    // signed loads
    MEM_LB   = 4'd1,
    MEM_LH   = 4'd2,
    MEM_LW   = 4'd3,
    // zero-extended loads
    MEM_LBU  = 4'd4,
    MEM_LHU  = 4'd5,
    // stores, never write a gpr
    MEM_SB   = 4'd6,
    MEM_SH   = 4'd7,
    MEM_SW   = 4'd8
  } mem_op_e;

endpackage

`default_nettype wire

/* stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one instruction slot between two pipeline stages
// no handshake, a new slot every cycle
interface stage_if;

  // instruction address
  rv_types_pkg::xlen_t pc;

  // instruction word, nop for bubbles
  rv_types_pkg::inst_t inst;

  // destination gpr
  // zero for stores and bubbles
  rv_types_pkg::reg_addr_t rd_addr;

  // load data or alu result
  rv_types_pkg::xlen_t data;

  // producing stage
  modport src (
    output pc,
    output inst,
    output rd_addr,
    output data
  );

  // consuming stage
  modport dst (
    input pc,
    input inst,
    input rd_addr,
    input data
  );

endinterface

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module mem_stage (
  input  wire logic                     clk,
  input  wire logic                     reset_i,
  input  wire rv_types_pkg::xlen_t      ex_pc_i,
  input  wire rv_types_pkg::inst_t      ex_inst_i,
  input  wire rv_types_pkg::reg_addr_t  ex_rd_addr_i,
  input  wire rv_types_pkg::xlen_t      ex_alu_result_i,
  input  wire rv_types_pkg::xlen_t      ex_store_data_i,
  input  wire rv_ctrl_pkg::mem_op_e     ex_mem_op_i,
  stage_if.src                          out_if
);

  // word organized, no reset on the array
  rv_types_pkg::xlen_t dmem [`DMEM_WORDS];

  rv_types_pkg::dmem_addr_t word_idx;
  logic [1:0]               byte_off;
  rv_types_pkg::xlen_t      rd_word;
  rv_types_pkg::xlen_t      ld_shift;
  rv_types_pkg::xlen_t      ld_data;
  rv_types_pkg::xlen_t      st_data;
  rv_types_pkg::byte_en_t   st_be;
  logic                     is_store;

  // alu result is the byte address
  assign word_idx = ex_alu_result_i[$bits(rv_types_pkg::dmem_addr_t)+1:2];
  assign byte_off = ex_alu_result_i[1:0];

  // async read, value usable this cycle
  assign rd_word  = dmem[word_idx];
  // addressed byte or half moved down to bit 0
  assign ld_shift = rd_word >> {byte_off, 3'b000};

  assign is_store = (ex_mem_op_i == rv_ctrl_pkg::MEM_SB) ||
                    (ex_mem_op_i == rv_ctrl_pkg::MEM_SH) ||
                    (ex_mem_op_i == rv_ctrl_pkg::MEM_SW);

  // load extend, everything else keeps the alu result
  always_comb begin
    case (ex_mem_op_i)
      rv_ctrl_pkg::MEM_LB:  ld_data = {{(`XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
      rv_ctrl_pkg::MEM_LH:  ld_data = {{(`XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
      rv_ctrl_pkg::MEM_LW:  ld_data = rd_word;
      rv_ctrl_pkg::MEM_LBU: ld_data = {{(`XLEN-8){1'b0}}, ld_shift[7:0]};
      rv_ctrl_pkg::MEM_LHU: ld_data = {{(`XLEN-16){1'b0}}, ld_shift[15:0]};
      default:              ld_data = ex_alu_result_i;
    endcase
  end

  // lane enables and replicated store data
  always_comb begin
    st_be   = '0;
    st_data = ex_store_data_i;
    case (ex_mem_op_i)
      rv_ctrl_pkg::MEM_SB: begin
        st_be   = 4'b0001 << byte_off;
        st_data = {4{ex_store_data_i[7:0]}};
      end
      rv_ctrl_pkg::MEM_SH: begin
        // bit 0 of the offset is ignored, misaligned halves are flagged below
        st_be   = 4'b0011 << {byte_off[1], 1'b0};
        st_data = {2{ex_store_data_i[15:0]}};
      end
      rv_ctrl_pkg::MEM_SW: begin
        st_be = '1;
      end
      default: begin
        st_be = '0;
      end
    endcase
  end

  // byte lane write at the edge
  // no stores land while in reset
  always_ff @(posedge clk) begin
    if (!reset_i) begin
      for (int lane = 0; lane < `XLEN/8; lane++) begin
        if (st_be[lane]) begin
          dmem[word_idx][lane*8 +: 8] <= st_data[lane*8 +: 8];
        end
      end
    end
  end

  // slot to mem/wb
  assign out_if.pc      = ex_pc_i;
  assign out_if.inst    = ex_inst_i;
  // stores never retire into the gpr file
  assign out_if.rd_addr = is_store ? '0 : ex_rd_addr_i;
  assign out_if.data    = ld_data;

  // halfword accesses on even addresses
  a_half_aligned: assert property (@(posedge clk) disable iff (reset_i)
    (ex_mem_op_i inside {rv_ctrl_pkg::MEM_LH, rv_ctrl_pkg::MEM_LHU, rv_ctrl_pkg::MEM_SH})
    |-> (byte_off[0] == 1'b0))
    else $error("misaligned halfword access at %h", ex_alu_result_i);

  // word accesses on word boundaries
  a_word_aligned: assert property (@(posedge clk) disable iff (reset_i)
    (ex_mem_op_i inside {rv_ctrl_pkg::MEM_LW, rv_ctrl_pkg::MEM_SW})
    |-> (byte_off == 2'b00))
    else $error("misaligned word access at %h", ex_alu_result_i);

endmodule

`default_nettype wire

/* mem_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module mem_wb (
  input  wire logic clk,
  input  wire logic reset_i,
  input  wire logic stall_i,
  input  wire logic flush_i,
  stage_if.dst      in_if,
  stage_if.src      out_if
);

  // pipeline field registers
  rv_types_pkg::xlen_t     pc_q;
  rv_types_pkg::inst_t     inst_q;
  rv_types_pkg::reg_addr_t rd_addr_q;
  rv_types_pkg::xlen_t     data_q;

  // stall wins over flush
  // flush loads a bubble, same values as reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q      <= '0;
      inst_q    <= `INST_NOP;
      rd_addr_q <= '0;
      data_q    <= '0;
    end else if (!stall_i) begin
      if (flush_i) begin
        pc_q      <= '0;
        inst_q    <= `INST_NOP;
        // rd zero, the bubble writes no gpr
        rd_addr_q <= '0;
        data_q    <= '0;
      end else begin
        pc_q      <= in_if.pc;
        inst_q    <= in_if.inst;
        rd_addr_q <= in_if.rd_addr;
        data_q    <= in_if.data;
      end
    end
  end

  // towards writeback
  assign out_if.pc      = pc_q;
  assign out_if.inst    = inst_q;
  assign out_if.rd_addr = rd_addr_q;
  assign out_if.data    = data_q;

  // a stalled edge leaves the whole slot untouched, flush included
  a_stall_holds: assert property (@(posedge clk) disable iff (reset_i)
    stall_i |=> ($stable(out_if.pc) && $stable(out_if.inst) &&
                 $stable(out_if.rd_addr) && $stable(out_if.data)))
    else $error("mem/wb slot changed during stall");

endmodule

`default_nettype wire

/* wb_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module wb_regfile (
  input  wire logic                    clk,
  input  wire logic                    reset_i,
  stage_if.dst                         in_if,
  input  wire rv_types_pkg::reg_addr_t rf_raddr_i,
  output rv_types_pkg::xlen_t          rf_rdata_o
);

  // architectural register count
  localparam int num_regs = 1 << `REG_ADDRWIDTH;

  // storage for x1..x31 only
  // x0 has none
  rv_types_pkg::xlen_t regs [1:num_regs-1];

  logic wr_en;

  // rd zero marks a slot without writeback
  assign wr_en = (in_if.rd_addr != '0);

  // write lands at the edge
  // visible on the read port right after
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[in_if.rd_addr] <= in_if.data;
    end
  end

  // combinational debug read
  // x0 decoded to zero here
  always_comb begin
    if (rf_raddr_i == '0) begin
      rf_rdata_o = '0;
    end else begin
      rf_rdata_o = regs[rf_raddr_i];
    end
  end

endmodule

`default_nettype wire

/* mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
  input  wire logic                    clk,
  input  wire logic                    reset_i,
  // instruction leaving execute
  input  wire rv_types_pkg::xlen_t     ex_pc_i,
  input  wire rv_types_pkg::inst_t     ex_inst_i,
  input  wire rv_types_pkg::reg_addr_t ex_rd_addr_i,
  input  wire rv_types_pkg::xlen_t     ex_alu_result_i,
  input  wire rv_types_pkg::xlen_t     ex_store_data_i,
  input  wire rv_ctrl_pkg::mem_op_e    ex_mem_op_i,
  // stands in for the hazard unit
  input  wire logic                    stall_i,
  input  wire logic                    flush_i,
  // debug read port
  input  wire rv_types_pkg::reg_addr_t rf_raddr_i,
  output rv_types_pkg::xlen_t          rf_rdata_o,
  // slot in writeback
  output rv_types_pkg::xlen_t          wb_pc_o,
  output rv_types_pkg::inst_t          wb_inst_o,
  output rv_types_pkg::reg_addr_t      wb_rd_addr_o,
  output rv_types_pkg::xlen_t          wb_data_o
);

  // mem -> mem/wb
  stage_if mem_if ();
  // mem/wb -> writeback
  stage_if wb_if ();

  // loads and stores
  mem_stage u_mem_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .ex_pc_i         (ex_pc_i),
    .ex_inst_i       (ex_inst_i),
    .ex_rd_addr_i    (ex_rd_addr_i),
    .ex_alu_result_i (ex_alu_result_i),
    .ex_store_data_i (ex_store_data_i),
    .ex_mem_op_i     (ex_mem_op_i),
    .out_if          (mem_if.src)
  );

  // pipeline register
  mem_wb u_mem_wb (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .in_if   (mem_if.dst),
    .out_if  (wb_if.src)
  );

  // gpr write
  wb_regfile u_wb_regfile (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_if      (wb_if.dst),
    .rf_raddr_i (rf_raddr_i),
    .rf_rdata_o (rf_rdata_o)
  );

  // writeback slot visible outside
  assign wb_pc_o      = wb_if.pc;
  assign wb_inst_o    = wb_if.inst;
  assign wb_rd_addr_o = wb_if.rd_addr;
  assign wb_data_o    = wb_if.data;

endmodule

`default_nettype wire

/* tb_mem_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_mem_wb;

  // cycle budget per test
  // the sum sets the watchdog limit
  localparam int reset_cycles = 40;
  localparam int pass_cycles  = 20;
  localparam int ldst_cycles  = 70;
  localparam int stall_cycles = 10;
  localparam int flush_cycles = 40;
  localparam int total_cycles = reset_cycles + pass_cycles + ldst_cycles +
                                stall_cycles + flush_cycles;
  localparam int timeout_ns   = total_cycles * 10 + 200;

  logic                    clk;
  logic                    reset_i;
  rv_types_pkg::xlen_t     ex_pc_i;
  rv_types_pkg::inst_t     ex_inst_i;
  rv_types_pkg::reg_addr_t ex_rd_addr_i;
  rv_types_pkg::xlen_t     ex_alu_result_i;
  rv_types_pkg::xlen_t     ex_store_data_i;
  rv_ctrl_pkg::mem_op_e    ex_mem_op_i;
  logic                    stall_i;
  logic                    flush_i;
  rv_types_pkg::reg_addr_t rf_raddr_i;
  rv_types_pkg::xlen_t     rf_rdata_o;
  rv_types_pkg::xlen_t     wb_pc_o;
  rv_types_pkg::inst_t     wb_inst_o;
  rv_types_pkg::reg_addr_t wb_rd_addr_o;
  rv_types_pkg::xlen_t     wb_data_o;

  // reference model of memory and gpr file
  rv_types_pkg::xlen_t exp_mem [`DMEM_WORDS];
  rv_types_pkg::xlen_t exp_regs [32];

  // last slot that entered mem/wb
  rv_types_pkg::xlen_t     last_pc;
  rv_types_pkg::inst_t     last_inst;
  rv_types_pkg::reg_addr_t last_rd;
  rv_types_pkg::xlen_t     last_data;

  int errors;
  int checks;
  int seed;

  mem_wb_top dut (
    .clk             (clk),
    .reset_i         (reset_i),
    .ex_pc_i         (ex_pc_i),
    .ex_inst_i       (ex_inst_i),
    .ex_rd_addr_i    (ex_rd_addr_i),
    .ex_alu_result_i (ex_alu_result_i),
    .ex_store_data_i (ex_store_data_i),
    .ex_mem_op_i     (ex_mem_op_i),
    .stall_i         (stall_i),
    .flush_i         (flush_i),
    .rf_raddr_i      (rf_raddr_i),
    .rf_rdata_o      (rf_rdata_o),
    .wb_pc_o         (wb_pc_o),
    .wb_inst_o       (wb_inst_o),
    .wb_rd_addr_o    (wb_rd_addr_o),
    .wb_data_o       (wb_data_o)
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_xlen(input string what, input rv_types_pkg::xlen_t got,
                            input rv_types_pkg::xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input string what, input rv_types_pkg::inst_t got,
                            input rv_types_pkg::inst_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg_addr(input string what, input rv_types_pkg::reg_addr_t got,
                                input rv_types_pkg::reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) $display("%s: passed", name);
    else $display("%s: %0d errors", name, errors - errs_before);
  endtask

  // predicted load result
  // non-loads keep the address
  function automatic rv_types_pkg::xlen_t load_value(input rv_ctrl_pkg::mem_op_e op,
                                                     input rv_types_pkg::xlen_t addr);
    rv_types_pkg::xlen_t word;
    logic [7:0]          b;
    logic [15:0]         h;
    word = exp_mem[(addr >> 2) % `DMEM_WORDS];
    b = word[addr[1:0]*8 +: 8];
    h = addr[1] ? word[31:16] : word[15:0];
    case (op)
      rv_ctrl_pkg::MEM_LB:  return {{(`XLEN-8){b[7]}}, b};
      rv_ctrl_pkg::MEM_LBU: return {{(`XLEN-8){1'b0}}, b};
      rv_ctrl_pkg::MEM_LH:  return {{(`XLEN-16){h[15]}}, h};
      rv_ctrl_pkg::MEM_LHU: return {{(`XLEN-16){1'b0}}, h};
      rv_ctrl_pkg::MEM_LW:  return word;
      default:              return addr;
    endcase
  endfunction

  // byte lanes of a store into the model
  task automatic apply_store(input rv_ctrl_pkg::mem_op_e op, input rv_types_pkg::xlen_t addr,
                             input rv_types_pkg::xlen_t data);
    int idx;
    idx = (addr >> 2) % `DMEM_WORDS;
    case (op)
      rv_ctrl_pkg::MEM_SB: exp_mem[idx][addr[1:0]*8 +: 8] = data[7:0];
      rv_ctrl_pkg::MEM_SH: exp_mem[idx][addr[1]*16 +: 16] = data[15:0];
      rv_ctrl_pkg::MEM_SW: exp_mem[idx] = data;
      default: ;
    endcase
  endtask

  task automatic drive_idle();
    ex_pc_i         = '0;
    ex_inst_i       = '0;
    ex_rd_addr_i    = '0;
    ex_alu_result_i = '0;
    ex_store_data_i = '0;
    ex_mem_op_i     = rv_ctrl_pkg::MEM_NONE;
  endtask

  task automatic check_wb(input rv_types_pkg::xlen_t pc, input rv_types_pkg::inst_t inst,
                          input rv_types_pkg::reg_addr_t rd, input rv_types_pkg::xlen_t data);
    check_xlen("wb_pc_o", wb_pc_o, pc);
    check_inst("wb_inst_o", wb_inst_o, inst);
    check_reg_addr("wb_rd_addr_o", wb_rd_addr_o, rd);
    check_xlen("wb_data_o", wb_data_o, data);
  endtask

  // called at a falling edge
  // returns one falling edge later
  task automatic issue_slot(input rv_ctrl_pkg::mem_op_e op, input rv_types_pkg::xlen_t alu,
                            input rv_types_pkg::xlen_t st, input rv_types_pkg::reg_addr_t rd);
    logic is_st;
    is_st = op inside {rv_ctrl_pkg::MEM_SB, rv_ctrl_pkg::MEM_SH, rv_ctrl_pkg::MEM_SW};
    last_pc   = $random(seed);
    last_inst = $random(seed);
    last_rd   = is_st ? '0 : rd;
    last_data = load_value(op, alu);
    ex_pc_i         = last_pc;
    ex_inst_i       = last_inst;
    ex_rd_addr_i    = rd;
    ex_alu_result_i = alu;
    ex_store_data_i = st;
    ex_mem_op_i     = op;
    if (is_st) apply_store(op, alu, st);
    @(negedge clk);
    check_wb(last_pc, last_inst, last_rd, last_data);
    if (last_rd != '0) exp_regs[last_rd] = last_data;
  endtask

  // one debug port read per cycle
  // pipeline idle meanwhile
  task automatic scan_regs();
    for (int i = 0; i < 32; i++) begin
      drive_idle();
      rf_raddr_i = i[4:0];
      @(negedge clk);
      check_xlen($sformatf("x%0d", i), rf_rdata_o, exp_regs[i]);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    check_wb('0, `INST_NOP, '0, '0);
    scan_regs();
    report_test("reset_state", e0);
  endtask

  task automatic test_pass_through();
    int e0;
    rv_types_pkg::reg_addr_t rd;
    e0 = errors;
    for (int k = 0; k < 8; k++) begin
      // some slots aim at x0 on purpose
      rd = (k % 4 == 0) ? '0 : rv_types_pkg::reg_addr_t'($random(seed));
      rf_raddr_i = rd;
      issue_slot(rv_ctrl_pkg::MEM_NONE, $random(seed), '0, rd);
      drive_idle();
      @(negedge clk);
      check_xlen("rf_rdata_o after writeback", rf_rdata_o, exp_regs[rd]);
    end
    report_test("pass_through", e0);
  endtask

  task automatic test_store_load();
    int e0;
    rv_types_pkg::xlen_t base;
    e0 = errors;
    for (int w = 0; w < 4; w++) begin
      base = ($random(seed) & 32'hff) << 2;
      // stores carry a nonzero rd that must be dropped
      issue_slot(rv_ctrl_pkg::MEM_SW, base, $random(seed), 5'd9);
      issue_slot(rv_ctrl_pkg::MEM_SH, base + ($random(seed) & 2), $random(seed), 5'd10);
      issue_slot(rv_ctrl_pkg::MEM_SB, base + ($random(seed) & 3), $random(seed), 5'd11);
      issue_slot(rv_ctrl_pkg::MEM_LW, base, '0,
                 rv_types_pkg::reg_addr_t'($random(seed)));
      issue_slot(rv_ctrl_pkg::MEM_LH, base + ($random(seed) & 2), '0,
                 rv_types_pkg::reg_addr_t'($random(seed)));
      issue_slot(rv_ctrl_pkg::MEM_LHU, base + ($random(seed) & 2), '0,
                 rv_types_pkg::reg_addr_t'($random(seed)));
      issue_slot(rv_ctrl_pkg::MEM_LB, base + ($random(seed) & 3), '0,
                 rv_types_pkg::reg_addr_t'($random(seed)));
      issue_slot(rv_ctrl_pkg::MEM_LBU, base + ($random(seed) & 3), '0,
                 rv_types_pkg::reg_addr_t'($random(seed)));
    end
    scan_regs();
    report_test("store_load", e0);
  endtask

  task automatic test_stall();
    int e0;
    e0 = errors;
    issue_slot(rv_ctrl_pkg::MEM_NONE, $random(seed), '0, 5'd3);
    for (int k = 0; k < 4; k++) begin
      stall_i         = 1'b1;
      // flush under stall is ignored
      flush_i         = (k == 2);
      ex_pc_i         = $random(seed);
      ex_inst_i       = $random(seed);
      ex_rd_addr_i    = rv_types_pkg::reg_addr_t'($random(seed));
      ex_alu_result_i = $random(seed);
      ex_mem_op_i     = rv_ctrl_pkg::MEM_NONE;
      @(negedge clk);
      check_wb(last_pc, last_inst, last_rd, last_data);
    end
    stall_i = 1'b0;
    flush_i = 1'b0;
    issue_slot(rv_ctrl_pkg::MEM_NONE, $random(seed), '0, 5'd4);
    report_test("stall", e0);
  endtask

  task automatic test_flush();
    int e0;
    e0 = errors;
    issue_slot(rv_ctrl_pkg::MEM_NONE, $random(seed), '0, 5'd5);
    // slot for x7 is squashed and never written
    flush_i         = 1'b1;
    ex_pc_i         = $random(seed);
    ex_inst_i       = $random(seed);
    ex_rd_addr_i    = 5'd7;
    ex_alu_result_i = $random(seed);
    ex_mem_op_i     = rv_ctrl_pkg::MEM_NONE;
    @(negedge clk);
    check_wb('0, `INST_NOP, '0, '0);
    flush_i = 1'b0;
    issue_slot(rv_ctrl_pkg::MEM_NONE, $random(seed), '0, 5'd8);
    scan_regs();
    report_test("flush", e0);
  endtask

  // watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: tests still running after %0d ns", timeout_ns);
    $display("Errors found");
    $finish;
  end

  initial begin
    errors  = 0;
    checks  = 0;
    seed    = 32'hd5d4_5f61;
    reset_i = 1'b1;
    stall_i = 1'b0;
    flush_i = 1'b0;
    rf_raddr_i = '0;
    drive_idle();
    for (int i = 0; i < 32; i++) exp_regs[i] = '0;
    repeat (4) @(negedge clk);
    reset_i = 1'b0;
    test_reset_state();
    test_pass_through();
    test_store_load();
    test_stall();
    test_flush();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
rv_types_pkg.sv
rv_ctrl_pkg.sv
stage_if.sv
mem_stage.sv
mem_wb.sv
wb_regfile.sv
mem_wb_top.sv
tb_mem_wb.sv

/* Makefile */
# Verilator build of the MEM/WB back end and its testbench
# any variable below can be overridden, e.g. make run TOP=tb_mem_wb

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
